// File: filelist.f
hw/icache_pkg.sv
hw/cache_arrays.sv
hw/mru_replace.sv
hw/icache_ctrl.sv
hw/icache_top.sv
sim/mem_model.sv
sim/tb_icache.sv

// File: hw/cache_arrays.sv
`timescale 1ns/1ps

module cache_arrays (
    input  logic                    clk,
    input  logic                    resetn,
    input  icache_pkg::lookup_req_t lookup,
    input  icache_pkg::addr_u       req_buf,
    input  icache_pkg::refill_req_t refill,
    output icache_pkg::hit_result_t hit
);
    import icache_pkg::*;

    logic [NUM_WAYS-1:0] hit_vec;
    logic [WORD_W-1:0]   way_word [NUM_WAYS];
    logic [WORD_W-1:0]   word_sel;
    logic [1:0]          bank_sel;

    // Word within the line, bits above the byte offset
    assign bank_sel = req_buf.fields.offset[OFFSET_W-1:2];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
        logic [LINE_W-1:0]   data_mem [NUM_SETS];
        logic [NUM_SETS-1:0] valid_bits;
        logic [TAG_W-1:0]    tag_q;
        logic [LINE_W-1:0]   line_q;
        logic                valid_q;
        logic                way_we;

        assign way_we = refill.we && (refill.way == WAY_W'(w));

        always_ff @(posedge clk) begin
            if (way_we) begin
                tag_mem[refill.index]  <= refill.tag;
                data_mem[refill.index] <= refill.line;
            end
            if (lookup.rd) begin
                tag_q  <= tag_mem[lookup.index];
                line_q <= data_mem[lookup.index];
            end
        end

        // Valid bits start cleared
        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_bits <= '0;
                valid_q    <= 1'b0;
            end else begin
                if (way_we) begin
                    valid_bits[refill.index] <= 1'b1;
                end
                if (lookup.rd) begin
                    valid_q <= valid_bits[lookup.index];
                end
            end
        end

        assign hit_vec[w]  = valid_q && (tag_q == req_buf.fields.tag);
        assign way_word[w] = line_q[bank_sel*WORD_W +: WORD_W];
    end

    // At most one way hits, so an OR of masked words is enough
    always_comb begin
        word_sel = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            word_sel = word_sel | ({WORD_W{hit_vec[w]}} & way_word[w]);
        end
    end

    assign hit.hit_vec = hit_vec;
    assign hit.any_hit = |hit_vec;
    assign hit.word    = word_sel;

endmodule

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             valid,
    input  logic                             uncache,
    input  icache_pkg::addr_u                addr,
    output logic                             addr_ok,
    output logic                             data_ok,
    output logic [icache_pkg::WORD_W-1:0]    rdata,
    output logic                             rd_req,
    output logic                             rd_type,
    output icache_pkg::addr_u                rd_addr,
    input  logic                             rd_rdy,
    input  logic                             ret_valid,
    input  logic [icache_pkg::LINE_W-1:0]    ret_data,
    input  icache_pkg::hit_result_t          hit,
    input  logic [icache_pkg::WAY_W-1:0]     victim_way,
    output icache_pkg::lookup_req_t          lookup,
    output icache_pkg::addr_u                req_buf,
    output icache_pkg::refill_req_t          refill,
    output logic                             replace_strobe,
    output logic                             lookup_strobe
);
    import icache_pkg::*;

    state_t            state;
    state_t            next_state;
    logic              accept;
    logic              lookup_hit;
    logic              refill_done;
    logic              uresp_done;
    logic [WORD_W-1:0] critical_word;

    assign lookup_hit  = (state == LOOKUP) && hit.any_hit;
    assign refill_done = (state == REFILL) && ret_valid;
    assign uresp_done  = (state == URESP) && ret_valid;

    // A hit frees the pipeline for the next request in the same cycle
    assign addr_ok = valid && ((state == IDLE) || lookup_hit);
    assign accept  = valid && addr_ok;

    // Request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= addr;
        end
    end

    // Arrays are read with the live index so tags are out one cycle later
    assign lookup.rd     = accept && !uncache;
    assign lookup.index  = addr.fields.index;
    assign lookup_strobe = (state == LOOKUP);

    assign refill.we     = refill_done;
    assign refill.way    = victim_way;
    assign refill.index  = req_buf.fields.index;
    assign refill.tag    = req_buf.fields.tag;
    assign refill.line   = ret_data;
    assign replace_strobe = refill_done;

    // Memory read port
    assign rd_req  = (state == REPLACE) || (state == UREQ);
    assign rd_type = (state == REPLACE);

    always_comb begin
        rd_addr = req_buf;
        if (state == REPLACE) begin
            rd_addr.fields.offset = '0;
        end
    end

    assign critical_word = ret_data[req_buf.fields.offset[OFFSET_W-1:2]*WORD_W +: WORD_W];

    assign data_ok = lookup_hit || refill_done || uresp_done;

    always_comb begin
        rdata = '0;
        if (lookup_hit) begin
            rdata = hit.word;
        end else if (refill_done) begin
            rdata = critical_word;
        end else if (uresp_done) begin
            rdata = ret_data[WORD_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit.any_hit) begin
                    next_state = REPLACE;
                end else if (accept) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end else begin
                    next_state = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            UREQ: begin
                if (rd_rdy) begin
                    next_state = URESP;
                end
            end
            URESP: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: hw/icache_pkg.sv
package icache_pkg;

    // Cache geometry
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 256;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int WAY_W    = 2;
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 128;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Flat word for uncached reads and rd_addr, fields for lookups
    typedef union packed {
        logic [WORD_W-1:0] word;
        addr_fields_t      fields;
    } addr_u;

    typedef struct packed {
        logic               rd;
        logic [INDEX_W-1:0] index;
    } lookup_req_t;

    typedef struct packed {
        logic               we;
        logic [WAY_W-1:0]   way;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        logic [LINE_W-1:0]  line;
    } refill_req_t;

    typedef struct packed {
        logic [NUM_WAYS-1:0] hit_vec;
        logic                any_hit;
        logic [WORD_W-1:0]   word;
    } hit_result_t;

    typedef enum logic [5:0] {
        IDLE    = 6'b000001,
        LOOKUP  = 6'b000010,
        REPLACE = 6'b000100,
        REFILL  = 6'b001000,
        UREQ    = 6'b010000,
        URESP   = 6'b100000
    } state_t;

endpackage

// File: hw/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          valid,
    input  logic                          uncache,
    input  icache_pkg::addr_u             addr,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [icache_pkg::WORD_W-1:0] rdata,
    output logic                          rd_req,
    output logic                          rd_type,
    output icache_pkg::addr_u             rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic [icache_pkg::LINE_W-1:0] ret_data
);
    import icache_pkg::*;

    lookup_req_t      lookup;
    addr_u            req_buf;
    refill_req_t      refill;
    hit_result_t      hit;
    logic [WAY_W-1:0] victim_way;
    logic             replace_strobe;
    logic             lookup_strobe;

    icache_ctrl icache_ctrl_inst (
        .clk            (clk),
        .resetn         (resetn),
        .valid          (valid),
        .uncache        (uncache),
        .addr           (addr),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .rdata          (rdata),
        .rd_req         (rd_req),
        .rd_type        (rd_type),
        .rd_addr        (rd_addr),
        .rd_rdy         (rd_rdy),
        .ret_valid      (ret_valid),
        .ret_data       (ret_data),
        .hit            (hit),
        .victim_way     (victim_way),
        .lookup         (lookup),
        .req_buf        (req_buf),
        .refill         (refill),
        .replace_strobe (replace_strobe),
        .lookup_strobe  (lookup_strobe)
    );

    cache_arrays cache_arrays_inst (
        .clk     (clk),
        .resetn  (resetn),
        .lookup  (lookup),
        .req_buf (req_buf),
        .refill  (refill),
        .hit     (hit)
    );

    mru_replace mru_replace_inst (
        .clk            (clk),
        .resetn         (resetn),
        .lookup_strobe  (lookup_strobe),
        .replace_strobe (replace_strobe),
        .hit_vec        (hit.hit_vec),
        .index          (req_buf.fields.index),
        .victim_way     (victim_way)
    );

endmodule

// File: hw/mru_replace.sv
`timescale 1ns/1ps

module mru_replace (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            lookup_strobe,
    input  logic                            replace_strobe,
    input  logic [icache_pkg::NUM_WAYS-1:0] hit_vec,
    input  logic [icache_pkg::INDEX_W-1:0]  index,
    output logic [icache_pkg::WAY_W-1:0]    victim_way
);
    import icache_pkg::*;

    logic [NUM_WAYS-1:0] mru [NUM_SETS];
    logic [NUM_WAYS-1:0] cur_bits;
    logic [NUM_WAYS-1:0] touch_vec;
    logic [NUM_WAYS-1:0] next_bits;
    logic [WAY_W-1:0]    free_way;
    logic                do_touch;
    logic                lookup_miss;

    assign cur_bits    = mru[index];
    assign lookup_miss = lookup_strobe && !(|hit_vec);

    // Way touched this cycle, if any
    always_comb begin
        touch_vec = '0;
        if (lookup_strobe) begin
            touch_vec = hit_vec;
        end else if (replace_strobe) begin
            touch_vec[victim_way] = 1'b1;
        end
    end

    assign do_touch = |touch_vec;

    // Once every way is marked, only the touched one stays set
    always_comb begin
        next_bits = cur_bits | touch_vec;
        if (&next_bits) begin
            next_bits = touch_vec;
        end
    end

    // Lowest-numbered way with a clear bit
    always_comb begin
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!cur_bits[w]) begin
                free_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                mru[s] <= '0;
            end
        end else if (do_touch) begin
            mru[index] <= next_bits;
        end
    end

    // Held through REPLACE and REFILL
    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_way <= '0;
        end else if (lookup_miss) begin
            victim_way <= free_way;
        end
    end

endmodule

// File: sim/icache_tests.txt
// uncache  address   expected_word  memory_read
// All fields hex, one request per line
1 00001004 5a5a1004 1
1 00001004 5a5a1004 1
1 00002007 5a5a2004 1
// Cold miss in set 0x10, then hits on the same line
0 00010108 5a5b0108 1
0 00010100 5a5b0100 0
0 0001010c 5a5b010c 0
0 00010104 5a5b0104 0
1 00003000 5a5a3000 1
// Five tags in set 0x20
0 00100200 5a4a0200 1
0 00200204 5a7a0204 1
0 00300208 5a6a0208 1
0 0040020c 5a1a020c 1
0 00500200 5a0a0200 1
// Re-accesses under the MRU rule
0 00200208 5a7a0208 0
0 0030020c 5a6a020c 0
0 00100204 5a4a0204 1
0 00500204 5a0a0204 1
0 00400200 5a1a0200 0
0 00300200 5a6a0200 0
0 00200200 5a7a0200 1
0 00100208 5a4a0208 1
0 0040020c 5a1a020c 0
0 00200204 5a7a0204 0
0 0010020c 5a4a020c 0
0 00500208 5a0a0208 1
0 00300204 5a6a0204 1
0 00010100 5a5b0100 0

// File: sim/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          rd_req,
    input  logic                          rd_type,
    input  icache_pkg::addr_u             rd_addr,
    output logic                          rd_rdy,
    output logic                          ret_valid,
    output logic [icache_pkg::LINE_W-1:0] ret_data
);
    import icache_pkg::*;

    logic [31:0]       lcg_state;
    logic [31:0]       rnd;
    logic [WORD_W-1:0] req_addr;
    logic              line_read;
    int                delay_cycles;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Word held at a byte address
    function automatic logic [WORD_W-1:0] rule_word(logic [WORD_W-1:0] a);
        return {a[WORD_W-1:2], 2'b00} ^ 32'h5A5A0000;
    endfunction

    function automatic logic [LINE_W-1:0] line_data(logic [WORD_W-1:0] a);
        logic [LINE_W-1:0] line;
        for (int i = 0; i < LINE_W / WORD_W; i++) begin
            line[i*WORD_W +: WORD_W] = rule_word({a[WORD_W-1:4], 4'h0} + 32'(i * 4));
        end
        return line;
    endfunction

    initial begin
        lcg_state = 32'd21173;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                rnd = next_rand();
                delay_cycles = int'(rnd[17:16]);
                repeat (delay_cycles) @(negedge clk);
                line_read = rd_type;
                req_addr  = rd_addr.word;
                rd_rdy <= 1'b1;
                @(negedge clk);
                rd_rdy <= 1'b0;
                rnd = next_rand();
                delay_cycles = int'(rnd[17:16]);
                repeat (delay_cycles) @(negedge clk);
                if (line_read) begin
                    ret_data <= line_data(req_addr);
                end else begin
                    // Junk above the word so a wrong lane shows up
                    rnd = next_rand();
                    ret_data <= {rnd, ~rnd, rnd ^ 32'hFFFF0000, rule_word(req_addr)};
                end
                ret_valid <= 1'b1;
                @(negedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int NUM_TESTS      = 27;
    localparam int TIMEOUT_CYCLES = 40 * NUM_TESTS;

    typedef struct packed {
        logic              uncache;
        addr_u             addr;
        logic [WORD_W-1:0] word;
        logic              mem_read;
    } test_entry_t;

    logic              clk;
    logic              resetn;
    logic              valid;
    logic              uncache;
    addr_u             addr;
    logic              addr_ok;
    logic              data_ok;
    logic [WORD_W-1:0] rdata;
    logic              rd_req;
    logic              rd_type;
    addr_u             rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    logic [LINE_W-1:0] ret_data;

    logic [31:0] test_mem [4*NUM_TESTS];
    test_entry_t tests [NUM_TESTS];
    test_entry_t pending [$];
    int          pending_cycle [$];
    test_entry_t head;
    int          head_cycle;
    int          cycle_count  = 0;
    int          accept_count = 0;
    int          resp_count   = 0;
    int          reads_seen   = 0;
    int          prev_accept  = 0;
    logic        prev_was_hit = 1'b0;
    logic        read_waiting = 1'b0;
    logic        held_type;
    addr_u       held_addr;

    icache_top icache_top_inst (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .uncache   (uncache),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    mem_model mem_model_inst (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_word(string name, logic [WORD_W-1:0] got, logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_addr(string name, addr_u got, addr_u exp);
        if (got.word !== exp.word) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got.word, exp.word));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_cycles(string name, int got, int exp);
        if (got != exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    // Four hex fields per request
    task automatic load_tests();
        $readmemh("sim/icache_tests.txt", test_mem);
        for (int k = 0; k < 4 * NUM_TESTS; k++) begin
            if ($isunknown(test_mem[k])) begin
                fail_run("Tests file sim/icache_tests.txt is missing or has too few entries");
            end
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            tests[i].uncache  = test_mem[4*i][0];
            tests[i].addr     = test_mem[4*i+1];
            tests[i].word     = test_mem[4*i+2];
            tests[i].mem_read = test_mem[4*i+3][0];
        end
    endtask

    // Line reads ask for the aligned line, word reads for the full address
    function automatic addr_u expected_rd_addr(test_entry_t t);
        addr_u a;
        a = t.addr;
        if (!t.uncache) begin
            a.fields.offset = '0;
        end
        return a;
    endfunction

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: only %0d of %0d responses arrived within %0d cycles",
                               resp_count, NUM_TESTS, TIMEOUT_CYCLES));
        end
        if (resetn) begin
            // Under back-pressure the read request must not move
            if (read_waiting) begin
                check_flag("rd_req held", rd_req, 1'b1);
                check_addr("rd_addr held", rd_addr, held_addr);
                check_flag("rd_type held", rd_type, held_type);
            end
            read_waiting = 1'b0;
            if (rd_req) begin
                check_flag("data_ok during read request", data_ok, 1'b0);
                check_flag("addr_ok during read request", addr_ok, 1'b0);
                if (rd_rdy) begin
                    if (pending.size() == 0) begin
                        fail_run("Memory read issued with no request outstanding");
                    end else begin
                        check_flag("rd_type", rd_type, !pending[0].uncache);
                        check_addr("rd_addr", rd_addr, expected_rd_addr(pending[0]));
                        reads_seen++;
                    end
                end else begin
                    read_waiting = 1'b1;
                    held_addr = rd_addr;
                    held_type = rd_type;
                end
            end
            // Returned data reaches the processor in the same cycle
            if (ret_valid) begin
                check_flag("data_ok with ret_valid", data_ok, 1'b1);
            end
            if (data_ok) begin
                if (pending.size() == 0) begin
                    fail_run("data_ok seen with no request outstanding");
                end else begin
                    head = pending.pop_front();
                    head_cycle = pending_cycle.pop_front();
                    check_word("rdata", rdata, head.word);
                    check_flag("memory read", reads_seen != 0, head.mem_read);
                    if (!head.uncache && !head.mem_read) begin
                        check_cycles("hit data_ok latency", cycle_count - head_cycle, 1);
                    end
                    reads_seen = 0;
                    resp_count++;
                end
            end
            if (valid && addr_ok) begin
                // A hit frees the port for the very next cycle
                if (prev_was_hit) begin
                    check_cycles("back-to-back accept distance", cycle_count - prev_accept, 1);
                end
                pending.push_back(tests[accept_count]);
                pending_cycle.push_back(cycle_count);
                prev_was_hit = !tests[accept_count].uncache && !tests[accept_count].mem_read;
                prev_accept = cycle_count;
                accept_count++;
            end
        end
    end

    initial begin
        resetn  = 1'b0;
        valid   = 1'b0;
        uncache = 1'b0;
        addr    = '0;
        load_tests();
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            valid   = 1'b1;
            uncache = tests[i].uncache;
            addr    = tests[i].addr;
            do @(negedge clk); while (accept_count <= i);
        end
        valid   = 1'b0;
        uncache = 1'b0;
        while (resp_count < NUM_TESTS) @(negedge clk);
        // Give a stray data_ok time to show
        repeat (4) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
